/* hw/obj_pkg.sv */
// sprite layer shared definitions
// widths, the scanner to drawer descriptor and the FSM encodings
`default_nettype none

package obj_pkg;

    localparam int obj_entries  = 102; // 5-byte entries that fit in 512 bytes
    localparam int obj_bytes    = 5;
    localparam int max_per_line = 32;
    localparam int line_width   = 256;

    typedef logic [8:0]  ram_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [17:0] rom_addr_t; // bank, id, row, word
    typedef logic [15:0] rom_word_t; // four 4bpp pixels, bit planes interleaved
    typedef logic [8:0]  xpos_t;     // 256 and up is off screen
    typedef logic [7:0]  pxl_t;      // palette in high nibble, color in low

    // one tile row to draw
    typedef struct packed {
        logic [3:0] bank;
        logic [3:0] palette;
        logic [7:0] id;
        logic [3:0] row;
        logic       hflip;
        xpos_t      x;
    } obj_desc_t;

    typedef enum logic [2:0] {
        scan_idle,
        scan_read_y,
        scan_read_attr,
        scan_read_rest,
        scan_wait_draw
    } scan_state_t;

    typedef enum logic [1:0] {
        draw_idle,
        draw_fetch,
        draw_shift
    } draw_state_t;

endpackage

`default_nettype wire

/* hw/obj_ram.sv */
// object attribute RAM, 512 bytes
// single port, CPU has priority over the line scanner
`default_nettype none

module obj_ram
    import obj_pkg::*;
(
    input  wire       clk,
    input  wire       cpu_cs,
    input  wire       cpu_wr_n,
    input  ram_addr_t cpu_addr,
    input  byte_t     cpu_din,
    input  ram_addr_t scan_addr,
    output byte_t     dout
);

    byte_t     mem [2**$bits(ram_addr_t)];
    ram_addr_t addr;
    logic      we;

    // scanner reads whatever the CPU points at while it is selected
    assign addr = cpu_cs ? cpu_addr : scan_addr;
    assign we   = cpu_cs & ~cpu_wr_n;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= cpu_din;
        end
        dout <= mem[addr]; // one clock read latency
    end

endmodule

`default_nettype wire

/* hw/obj_scan.sv */
// per-line sprite scanner
// walks the object table after hblank and hands visible sprites to the drawer
// stops at 32 drawn sprites or at the last entry
`default_nettype none

module obj_scan
    import obj_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       hbl,
    input  byte_t     vpos,
    input  byte_t     ram_dout,
    output ram_addr_t scan_addr,
    input  wire       draw_done,
    output logic      draw_req,
    output obj_desc_t desc,
    output logic      line_sel
);

    localparam ram_addr_t last_entry = ram_addr_t'((obj_entries - 1) * obj_bytes);

    scan_state_t state;
    ram_addr_t   base;     // first byte of current entry
    logic [2:0]  offset;
    logic        wait_mem;
    logic [1:0]  step;
    logic [5:0]  drawn;
    logic        hbl_d;
    logic        hbl_fall;
    logic        last;
    logic        in_zone;
    byte_t       y_lat;
    byte_t       attr;
    byte_t       dy;

    assign scan_addr = base + ram_addr_t'(offset);
    assign hbl_fall  = hbl_d & ~hbl;
    assign last      = base == last_entry;
    assign dy        = vpos - y_lat;       // wraps mod 256
    assign in_zone   = dy[7:4] == 4'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= scan_idle;
            base     <= '0;
            offset   <= '0;
            wait_mem <= 1'b0;
            step     <= '0;
            drawn    <= '0;
            hbl_d    <= 1'b0;
            line_sel <= 1'b0;
            draw_req <= 1'b0;
            y_lat    <= '0;
            attr     <= '0;
            desc     <= '0;
        end else begin
            hbl_d    <= hbl;
            draw_req <= 1'b0;
            if (hbl_fall) begin
                line_sel <= ~line_sel; // swap buffer halves every line
            end
            case (state)
                scan_idle: begin
                    if (hbl_fall) begin
                        state    <= scan_read_y;
                        base     <= '0;
                        offset   <= 3'd0;
                        wait_mem <= 1'b1;
                        drawn    <= '0;
                    end
                end
                scan_read_y: begin
                    wait_mem <= 1'b0;
                    if (!wait_mem) begin
                        y_lat    <= ram_dout;
                        offset   <= 3'd1;
                        wait_mem <= 1'b1;
                        state    <= scan_read_attr;
                    end
                end
                scan_read_attr: begin
                    wait_mem <= 1'b0;
                    if (wait_mem) begin
                        offset <= 3'd2; // prefetch bank/palette byte
                    end else begin
                        attr <= ram_dout;
                        if (!ram_dout[7] || !in_zone) begin
                            if (last) begin
                                state <= scan_idle;
                            end else begin
                                base     <= base + ram_addr_t'(obj_bytes);
                                offset   <= 3'd0;
                                wait_mem <= 1'b1;
                                state    <= scan_read_y;
                            end
                        end else begin
                            desc.row   <= dy[3:0];
                            desc.hflip <= ram_dout[3];
                            offset     <= 3'd3;
                            step       <= 2'd0;
                            state      <= scan_read_rest;
                        end
                    end
                end
                scan_read_rest: begin
                    step <= step + 2'd1;
                    case (step)
                        2'd0: begin
                            desc.palette <= ram_dout[7:4];
                            desc.bank    <= ram_dout[3:0];
                            offset       <= 3'd4;
                        end
                        2'd1: desc.id <= ram_dout;
                        default: begin
                            desc.x   <= {attr[1], ram_dout}; // x msb lives in attr
                            draw_req <= 1'b1;
                            state    <= scan_wait_draw;
                        end
                    endcase
                end
                scan_wait_draw: begin
                    if (draw_done) begin
                        drawn <= drawn + 6'd1;
                        if (last || drawn == 6'(max_per_line - 1)) begin
                            state <= scan_idle;
                        end else begin
                            base     <= base + ram_addr_t'(obj_bytes);
                            offset   <= 3'd0;
                            wait_mem <= 1'b1;
                            state    <= scan_read_y;
                        end
                    end
                end
                default: state <= scan_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/obj_draw.sv */
// sprite tile row drawer
// fetches four ROM words per row and writes opaque pixels to the line buffer
`default_nettype none

module obj_draw
    import obj_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        draw_req,
    input  obj_desc_t  desc,
    output rom_addr_t  rom_addr,
    input  rom_word_t  rom_data,
    input  wire        rom_ok,
    output logic       draw_done,
    output logic       wr_en,
    output byte_t      wr_x,
    output pxl_t       wr_pxl,
    input  wire        wr_busy
);

    draw_state_t state;
    obj_desc_t   cur;
    rom_word_t   word;
    logic [1:0]  wcnt;     // word within the row
    logic [1:0]  pcnt;     // pixel within the word
    logic [1:0]  pidx;
    logic [9:0]  xcnt;     // wide enough not to wrap back on screen
    logic [3:0]  color;
    logic        ok_dly;
    logic        stall;
    logic        start;
    logic        take;

    assign stall = wr_en & wr_busy; // line buffer is serving a read
    assign start = ~stall & (state == draw_idle) & draw_req;
    assign take  = ~stall & (state == draw_fetch) & ok_dly & rom_ok;
    assign pidx  = pcnt ^ {2{cur.hflip}};
    assign color = {word[{2'b11, pidx}], word[{2'b10, pidx}],
                    word[{2'b01, pidx}], word[{2'b00, pidx}]};

    always_ff @(posedge clk) begin
        if (start) begin
            cur <= desc;
        end
        if (take) begin
            word <= rom_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= draw_idle;
            rom_addr  <= '0;
            draw_done <= 1'b0;
            wr_en     <= 1'b0;
            wr_x      <= '0;
            wr_pxl    <= '0;
            wcnt      <= '0;
            pcnt      <= '0;
            xcnt      <= '0;
            ok_dly    <= 1'b0;
        end else begin
            draw_done <= 1'b0;
            ok_dly    <= rom_ok;
            if (!stall) begin
                wr_en <= 1'b0;
                case (state)
                    draw_idle: begin
                        if (draw_req) begin
                            rom_addr <= {desc.bank, desc.id, desc.row, {2{desc.hflip}}};
                            xcnt     <= {1'b0, desc.x};
                            wcnt     <= '0;
                            pcnt     <= '0;
                            ok_dly   <= 1'b0;
                            state    <= draw_fetch;
                        end
                    end
                    draw_fetch: begin
                        // rom_ok must hold for two clocks in a row
                        if (ok_dly && rom_ok) begin
                            pcnt  <= '0;
                            state <= draw_shift;
                        end
                    end
                    draw_shift: begin
                        wr_en  <= (color != 4'd0) && (xcnt < 10'(line_width));
                        wr_x   <= xcnt[7:0];
                        wr_pxl <= {cur.palette, color};
                        xcnt   <= xcnt + 10'd1;
                        pcnt   <= pcnt + 2'd1;
                        if (pcnt == 2'd3) begin
                            if (wcnt == 2'd3) begin
                                draw_done <= 1'b1;
                                state     <= draw_idle;
                            end else begin
                                wcnt     <= wcnt + 2'd1;
                                rom_addr <= {cur.bank, cur.id, cur.row,
                                             (wcnt + 2'd1) ^ {2{cur.hflip}}};
                                ok_dly   <= 1'b0;
                                state    <= draw_fetch;
                            end
                        end
                    end
                    default: state <= draw_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/obj_line_buf.sv */
// double line buffer, 2 x 256 pixels
// one half is drawn while the other is read out and then cleared in hblank
`default_nettype none

module obj_line_buf
    import obj_pkg::*;
(
    input  wire   clk,
    input  wire   rst,
    input  wire   hbl,
    input  wire   pxl_cen,
    input  wire   line_sel,
    input  wire   wr_en,
    input  byte_t wr_x,
    input  pxl_t  wr_pxl,
    output logic  wr_busy,
    output pxl_t  obj_pxl
);

    pxl_t       mem [2 * line_width];
    pxl_t       q;
    pxl_t       wdata;
    logic [8:0] addr;
    logic       we;
    logic       rd;
    logic       rd_d;
    byte_t      clr_cnt;
    byte_t      rd_ptr;

    assign rd      = pxl_cen & ~hbl;
    assign wr_busy = rd; // reads win the port, drawer retries next clock

    always_comb begin
        wdata = wr_pxl;
        if (hbl) begin
            addr  = {~line_sel, clr_cnt}; // wipe the half just shown
            we    = 1'b1;
            wdata = '0;
        end else if (rd) begin
            addr = {~line_sel, rd_ptr};
            we   = 1'b0;
        end else begin
            addr = {line_sel, wr_x};
            we   = wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clr_cnt <= '0;
            rd_ptr  <= '0;
            rd_d    <= 1'b0;
            obj_pxl <= '0;
        end else begin
            rd_d <= rd;
            if (hbl) begin
                clr_cnt <= clr_cnt + 8'd1;
                rd_ptr  <= '0;
            end else begin
                clr_cnt <= '0;
                if (rd) begin
                    rd_ptr <= rd_ptr + 8'd1;
                end
            end
            if (rd_d) begin
                obj_pxl <= q; // two clocks after the strobe
            end
        end
    end

endmodule

`default_nettype wire

/* hw/obj_layer.sv */
// sprite layer top
// object RAM, line scanner, tile drawer and double line buffer
`default_nettype none

module obj_layer
    import obj_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  ram_addr_t cpu_addr,
    input  wire       cpu_cs,
    input  wire       cpu_wr_n,
    input  byte_t     cpu_din,
    output byte_t     cpu_dout,
    input  byte_t     vpos,
    input  wire       hbl,
    input  wire       pxl_cen,
    output rom_addr_t rom_addr,
    input  rom_word_t rom_data,
    input  wire       rom_ok,
    output pxl_t      obj_pxl
);

    ram_addr_t scan_addr;
    obj_desc_t desc;
    logic      draw_req;
    logic      draw_done;
    logic      line_sel;
    logic      wr_en;
    byte_t     wr_x;
    pxl_t      wr_pxl;
    logic      wr_busy;

    obj_ram ram_i (
        .clk       (clk),
        .cpu_cs    (cpu_cs),
        .cpu_wr_n  (cpu_wr_n),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .scan_addr (scan_addr),
        .dout      (cpu_dout)
    );

    obj_scan scan_i (
        .clk       (clk),
        .rst       (rst),
        .hbl       (hbl),
        .vpos      (vpos),
        .ram_dout  (cpu_dout),   // same read port as the CPU
        .scan_addr (scan_addr),
        .draw_done (draw_done),
        .draw_req  (draw_req),
        .desc      (desc),
        .line_sel  (line_sel)
    );

    obj_draw draw_i (
        .clk       (clk),
        .rst       (rst),
        .draw_req  (draw_req),
        .desc      (desc),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .draw_done (draw_done),
        .wr_en     (wr_en),
        .wr_x      (wr_x),
        .wr_pxl    (wr_pxl),
        .wr_busy   (wr_busy)
    );

    obj_line_buf line_buf_i (
        .clk      (clk),
        .rst      (rst),
        .hbl      (hbl),
        .pxl_cen  (pxl_cen),
        .line_sel (line_sel),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_pxl   (wr_pxl),
        .wr_busy  (wr_busy),
        .obj_pxl  (obj_pxl)
    );

endmodule

`default_nettype wire

/* tb/obj_clk_gen.sv */
// testbench clock and reset source
// 10 unit clock period, reset held high for the first 8 cycles
`default_nettype none

module obj_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb/obj_layer_checker.sv */
// concurrent protocol checks for the sprite layer
// bound into obj_layer, sees the drawer state and internal strobes
`default_nettype none

module obj_layer_checker
    import obj_pkg::*;
(
    input wire         clk,
    input wire         rst,
    input wire         hbl,
    input wire         pxl_cen,
    input wire         rom_ok,
    input rom_addr_t   rom_addr,
    input wire         draw_req,
    input wire         draw_done,
    input wire         wr_en,
    input pxl_t        obj_pxl,
    input draw_state_t draw_state
);

    logic       pending;    // request seen, done not yet
    logic       hbl_d;
    logic       any_req;    // drawer used during this line
    logic       prev_empty;
    logic [1:0] falls;
    logic       empty_rd;
    int         fails = 0;  // failed assertions so far

    // a line is trusted once both buffer halves went through a clear
    assign empty_rd = pxl_cen & ~hbl & prev_empty & (falls == 2'd2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending    <= 1'b0;
            hbl_d      <= 1'b1;
            any_req    <= 1'b0;
            prev_empty <= 1'b0;
            falls      <= '0;
        end else begin
            hbl_d <= hbl;
            if (draw_req) begin
                pending <= 1'b1;
            end else if (draw_done) begin
                pending <= 1'b0;
            end
            if (hbl_d && !hbl) begin
                prev_empty <= ~any_req;
                any_req    <= draw_req;
                if (falls != 2'd2) begin
                    falls <= falls + 2'd1;
                end
            end else if (draw_req) begin
                any_req <= 1'b1;
            end
        end
    end

    rom_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (draw_state == draw_fetch && !rom_ok) |=> $stable(rom_addr))
        else begin
            $error("rom_addr moved while rom_ok was low");
            fails++;
        end

    no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        draw_req |-> !pending)
        else begin
            $error("draw_req issued while a draw was pending");
            fails++;
        end

    no_write_in_blank: assert property (@(posedge clk) disable iff (rst)
        hbl |-> !wr_en)
        else begin
            $error("line buffer write during hblank");
            fails++;
        end

    empty_line_zero: assert property (@(posedge clk) disable iff (rst)
        $past(empty_rd, 2) |-> obj_pxl == 8'h00)
        else begin
            $error("nonzero pixel on a line without sprites");
            fails++;
        end

endmodule

bind obj_layer obj_layer_checker checker_i (
    .clk        (clk),
    .rst        (rst),
    .hbl        (hbl),
    .pxl_cen    (pxl_cen),
    .rom_ok     (rom_ok),
    .rom_addr   (rom_addr),
    .draw_req   (draw_req),
    .draw_done  (draw_done),
    .wr_en      (wr_en),
    .obj_pxl    (obj_pxl),
    .draw_state (draw_i.state)
);

`default_nettype wire

/* tb/obj_layer_tb.sv */
// sprite layer testbench
// CPU bus, line timing and tile ROM model, with a line image model to compare against
`default_nettype none

module obj_layer_tb
    import obj_pkg::*;
();

    logic      clk;
    logic      rst;
    ram_addr_t cpu_addr;
    logic      cpu_cs;
    logic      cpu_wr_n;
    byte_t     cpu_din;
    byte_t     cpu_dout;
    byte_t     vpos;
    logic      hbl;
    logic      pxl_cen;
    rom_addr_t rom_addr;
    rom_word_t rom_data;
    logic      rom_ok;
    pxl_t      obj_pxl;

    integer seed = 34563;
    int     errors = 0;
    int     checks = 0;
    logic   gaps = 1'b0;      // random rom_ok drops
    logic   exp_valid = 1'b0;
    byte_t  ram_model [512];
    byte_t  rnd_data [512];
    pxl_t   exp_next [256];
    pxl_t   exp_cur [256];
    pxl_t   last_cap [256];
    pxl_t   plain [256];

    obj_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    obj_layer obj_layer_i (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .cpu_cs   (cpu_cs),
        .cpu_wr_n (cpu_wr_n),
        .cpu_din  (cpu_din),
        .cpu_dout (cpu_dout),
        .vpos     (vpos),
        .hbl      (hbl),
        .pxl_cen  (pxl_cen),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .obj_pxl  (obj_pxl)
    );

    // fixed scramble of the word address
    function automatic rom_word_t rom_word(input rom_addr_t a);
        logic [31:0] t;
        t = {14'd0, a} * 32'h9e37_79b1;
        return t[31:16];
    endfunction

    always @(negedge clk) begin
        rom_data <= rom_word(rom_addr);
        rom_ok   <= gaps ? (($random(seed) & 3) != 0) : 1'b1;
    end

    task automatic cpu_write(input int a, input byte_t d);
        @(negedge clk);
        cpu_cs       = 1'b1;
        cpu_wr_n     = 1'b0;
        cpu_addr     = ram_addr_t'(a);
        cpu_din      = d;
        ram_model[a] = d;
    endtask

    task automatic cpu_release();
        @(negedge clk);
        cpu_cs   = 1'b0;
        cpu_wr_n = 1'b1;
    endtask

    task automatic put_entry(input int e, input byte_t y, input byte_t attr,
                             input byte_t bp, input byte_t id, input byte_t x);
        cpu_write(e * 5, y);
        cpu_write(e * 5 + 1, attr);
        cpu_write(e * 5 + 2, bp);
        cpu_write(e * 5 + 3, id);
        cpu_write(e * 5 + 4, x);
        cpu_release();
    endtask

    // expected image of the tile rows scanned for line v
    task automatic compute_line(input byte_t v);
        int        e;
        int        px;
        int        col;
        int        i;
        int        sx;
        int        drawn;
        byte_t     a;
        byte_t     dy;
        rom_word_t d;
        logic [3:0] c;
        for (px = 0; px < line_width; px++) begin
            exp_next[px] = '0;
        end
        drawn = 0;
        for (e = 0; e < obj_entries && drawn < max_per_line; e++) begin
            a  = ram_model[e * 5 + 1];
            dy = v - ram_model[e * 5];
            if (a[7] && dy < 8'd16) begin
                for (px = 0; px < 16; px++) begin
                    col = a[3] ? 15 - px : px;
                    d   = rom_word({ram_model[e * 5 + 2][3:0], ram_model[e * 5 + 3],
                                    dy[3:0], 2'(col / 4)});
                    i   = col % 4;
                    c   = {d[i + 12], d[i + 8], d[i + 4], d[i]};
                    sx  = {a[1], ram_model[e * 5 + 4]} + px;
                    if (c != 4'd0 && sx < line_width) begin
                        exp_next[sx] = {ram_model[e * 5 + 2][7:4], c};
                    end
                end
                drawn++;
            end
        end
    endtask

    // one blank plus one active line; checks the image scanned on the line before
    task automatic run_line(input byte_t v, input int space);
        int p;
        @(negedge clk);
        vpos = v;
        hbl  = 1'b1;
        repeat (299) @(negedge clk);
        compute_line(v);
        hbl = 1'b0;
        @(negedge clk); // buffer halves swap on the clock after the fall
        for (p = 0; p < line_width; p++) begin
            pxl_cen = 1'b1;
            @(negedge clk);
            pxl_cen = 1'b0;
            @(negedge clk);
            last_cap[p] = obj_pxl; // two clocks after the strobe
            repeat (space - 2) @(negedge clk);
        end
        hbl = 1'b1;
        if (exp_valid) begin
            for (p = 0; p < line_width; p++) begin
                checks++;
                assert (last_cap[p] === exp_cur[p]) else begin
                    $display("CHECK FAILED obj_pxl x=%02h exp %02h got %02h",
                             p, exp_cur[p], last_cap[p]);
                    errors++;
                end
            end
        end
        exp_cur   = exp_next;
        exp_valid = 1'b1;
    endtask

    task automatic report_test(input int n, input string name, input int err0);
        if (errors == err0) begin
            $display("test %0d %s: ok", n, name);
        end else begin
            $display("test %0d %s: %0d errors", n, name, errors - err0);
        end
    endtask

    initial begin
        int a;
        int e;
        int t;
        int err0;
        cpu_addr = '0;
        cpu_cs   = 1'b0;
        cpu_wr_n = 1'b1;
        cpu_din  = '0;
        vpos     = '0;
        hbl      = 1'b1;
        pxl_cen  = 1'b0;
        rom_data = '0;
        rom_ok   = 1'b1;

        t = 0;
        @(negedge clk);
        while (rst && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (rst) begin
            $display("reset was never released");
            $display("Test failed");
            $finish;
        end else begin
            // 1: RAM write and read back
            err0 = errors;
            for (a = 0; a < 512; a++) begin
                rnd_data[a] = byte_t'($random(seed));
                cpu_write(a, rnd_data[a]);
            end
            for (a = 0; a < 512; a++) begin
                @(negedge clk);
                cpu_wr_n = 1'b1;
                cpu_addr = ram_addr_t'(a);
                @(negedge clk);
                checks++;
                assert (cpu_dout === rnd_data[a]) else begin
                    $display("CHECK FAILED cpu_dout addr %03h exp %02h got %02h",
                             a, rnd_data[a], cpu_dout);
                    errors++;
                end
            end
            for (a = 0; a < 512; a++) begin
                cpu_write(a, 8'h00);
            end
            cpu_release();
            report_test(1, "ram readback", err0);

            // 2: single sprite, after two empty lines that settle both halves
            err0 = errors;
            run_line(8'd1, 4);
            run_line(8'd2, 4);
            put_entry(0, 8'd40, 8'h80, 8'h35, 8'h12, 8'd60);
            run_line(8'd45, 4);
            run_line(8'd46, 4);
            report_test(2, "single sprite", err0);

            // 3: disabled, out of zone and clipped
            err0 = errors;
            put_entry(0, 8'd40, 8'h00, 8'h35, 8'h12, 8'd60);
            run_line(8'd45, 4);
            put_entry(0, 8'd100, 8'h80, 8'h35, 8'h12, 8'd60);
            run_line(8'd45, 4);
            put_entry(0, 8'd40, 8'h82, 8'h47, 8'h21, 8'h10);
            put_entry(1, 8'd40, 8'h80, 8'h59, 8'h33, 8'd250);
            run_line(8'd47, 4);
            run_line(8'd48, 4);
            report_test(3, "disable and clip", err0);

            // 4: hflip mirrors the unflipped row
            err0 = errors;
            put_entry(1, 8'd0, 8'h00, 8'h00, 8'h00, 8'd0);
            put_entry(0, 8'h20, 8'h80, 8'h6a, 8'h5c, 8'd100);
            run_line(8'h23, 4);
            run_line(8'h24, 4);
            plain = last_cap;
            put_entry(0, 8'h20, 8'h88, 8'h6a, 8'h5c, 8'd100);
            run_line(8'h23, 4);
            run_line(8'h24, 4);
            for (a = 0; a < 16; a++) begin
                checks++;
                assert (last_cap[100 + a] === plain[115 - a]) else begin
                    $display("CHECK FAILED obj_pxl x=%02h exp %02h got %02h",
                             100 + a, plain[115 - a], last_cap[100 + a]);
                    errors++;
                end
            end
            report_test(4, "hflip", err0);

            // 5: priority, then 40 sprites on one line with slower pixel rate
            err0 = errors;
            put_entry(0, 8'h50, 8'h80, 8'h1b, 8'h40, 8'd80);
            put_entry(1, 8'h50, 8'h80, 8'h2c, 8'h41, 8'd88);
            run_line(8'h55, 4);
            run_line(8'h56, 4);
            for (e = 0; e < 40; e++) begin
                put_entry(e, 8'h60, 8'h80, byte_t'({e[3:0], e[3:0]}),
                          byte_t'(e), byte_t'(e * 6));
            end
            run_line(8'h66, 6);
            run_line(8'h67, 6);
            report_test(5, "overlap and line limit", err0);

            // 6: rom_ok gaps, then clearing check on an empty table
            err0 = errors;
            for (e = 0; e < 40; e++) begin
                cpu_write(e * 5 + 1, 8'h00);
            end
            cpu_release();
            put_entry(0, 8'h70, 8'h80, 8'h93, 8'h77, 8'd10);
            put_entry(1, 8'h70, 8'h88, 8'ha4, 8'h78, 8'd20);
            put_entry(2, 8'h70, 8'h80, 8'hb5, 8'h79, 8'd200);
            gaps = 1'b1;
            run_line(8'h75, 4);
            run_line(8'h76, 4);
            for (e = 0; e < 3; e++) begin
                cpu_write(e * 5 + 1, 8'h00);
            end
            cpu_release();
            run_line(8'h77, 4);
            run_line(8'h78, 4);
            gaps = 1'b0;
            report_test(6, "rom gaps and clearing", err0);

            errors = errors + obj_layer_i.checker_i.fails;
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* obj_layer.f */
hw/obj_pkg.sv
hw/obj_ram.sv
hw/obj_scan.sv
hw/obj_draw.sv
hw/obj_line_buf.sv
hw/obj_layer.sv
tb/obj_clk_gen.sv
tb/obj_layer_checker.sv
tb/obj_layer_tb.sv

/* Makefile */
# Verilator build and run of the sprite layer testbench

VERILATOR ?= verilator
TOP       ?= obj_layer_tb
FILELIST  ?= obj_layer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
